//--- hdl/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Cache geometry
`define CACHE_WAYS        4
`define CACHE_SETS        16
`define CACHE_LINE_BITS   256
`define CACHE_ADDR_BITS   32

// Address split as tag | index | offset
`define CACHE_OFFSET_BITS 5
`define CACHE_INDEX_BITS  4
`define CACHE_TAG_BITS    23

`endif

//--- hdl/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        MESI_I,
        MESI_S,
        MESI_E,
        MESI_M
    } mesi_t;

    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_RD,
        BUS_INV
    } bus_cmd_e;

    typedef struct packed {
        mesi_t                      state;
        logic                       dirty;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef logic [`CACHE_LINE_BITS-1:0] line_t;
    typedef logic [1:0]                  way_t;

    typedef struct packed {
        logic [`CACHE_ADDR_BITS-1:0] addr;
        logic [3:0]                  rmask;
        logic [3:0]                  wmask;
        logic [31:0]                 wdata;
        logic                        valid;
    } cpu_req_t;

    typedef struct packed {
        logic                        read;
        logic                        write;
        logic [`CACHE_ADDR_BITS-1:0] addr;    // Always line aligned
        line_t                       wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        bus_cmd_e                    cmd;
        logic [`CACHE_ADDR_BITS-1:0] addr;
    } bus_cmd_t;

    typedef struct packed {
        logic valid;
        logic shared;    // Another cache holds the line
    } bus_rsp_t;

    typedef struct packed {
        logic                        valid;
        bus_cmd_e                    cmd;
        logic [`CACHE_ADDR_BITS-1:0] addr;
    } snoop_req_t;

    typedef struct packed {
        logic  valid;
        logic  hit;
        logic  dirty;
        line_t data;
    } snoop_rsp_t;

    // A line matches when it is present and the tags agree
    function automatic logic tag_hit(tag_entry_t e, logic [`CACHE_TAG_BITS-1:0] tag);
        return (e.state != MESI_I) && (e.tag == tag);
    endfunction

endpackage

//--- hdl/cache_bank.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_bank #(
    parameter type entry_t = logic [`CACHE_LINE_BITS-1:0],
    parameter int  DEPTH   = `CACHE_SETS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [$clog2(DEPTH)-1:0]      a_addr,
    input  logic                          a_we,
    input  logic [`CACHE_LINE_BITS/8-1:0] a_bmask,
    input  entry_t                        a_din,
    output entry_t                        a_dout,
    input  logic [$clog2(DEPTH)-1:0]      b_addr,
    input  logic                          b_we,
    input  entry_t                        b_din,
    output entry_t                        b_dout
);
    localparam int W = $bits(entry_t);

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] a_bits;    // Byte enables spread to bits

    always_comb begin
        for (int i = 0; i < W; i++) a_bits[i] = a_bmask[i / 8];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) mem[i] <= '0;    // All tags back to I
            a_dout <= '0;
            b_dout <= '0;
        end else begin
            if (a_we) mem[a_addr] <= (mem[a_addr] & ~a_bits) | (a_din & a_bits);
            if (b_we) mem[b_addr] <= b_din;
            a_dout <= entry_t'(mem[a_addr]);    // Old contents on a same-cycle write
            b_dout <= entry_t'(mem[b_addr]);
        end
    end

    // CPU side and snoop side never update the same set together
    assert property (@(posedge clk) disable iff (rst) !(a_we && b_we && a_addr == b_addr))
        else $error("cache_bank: both ports write entry %0d", a_addr);

endmodule

//--- hdl/plru_tree.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module plru_tree (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`CACHE_INDEX_BITS-1:0] index,
    input  logic                         touch,
    input  cache_pkg::way_t              touch_way,
    output cache_pkg::way_t              victim
);
    // Bit 2 picks the half, bit 1 the way in 0/1, bit 0 the way in 2/3
    logic [2:0] tree [`CACHE_SETS];
    logic [2:0] cur;

    assign cur    = tree[index];
    assign victim = {cur[2], cur[2] ? cur[0] : cur[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) tree[s] <= 3'b000;
        end else if (touch) begin
            // Point every node on the path away from the touched way
            if (touch_way[1]) begin
                tree[index] <= {1'b0, cur[1], ~touch_way[0]};
            end else begin
                tree[index] <= {1'b1, ~touch_way[0], cur[0]};
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) touch |-> !$isunknown(touch_way))
        else $error("plru_tree: touch with unknown way");

endmodule

//--- hdl/cache_controller.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_controller (
    input  logic                          clk,
    input  logic                          rst,
    input  cache_pkg::cpu_req_t           cpu_req,
    input  cache_pkg::mem_rsp_t           mem_rsp,
    input  logic                          bus_ready,
    input  cache_pkg::bus_rsp_t           bus_rsp,
    input  cache_pkg::tag_entry_t         tag_rd [`CACHE_WAYS],
    input  cache_pkg::line_t              data_rd [`CACHE_WAYS],
    input  cache_pkg::way_t               victim,
    output logic                          cpu_resp,
    output logic [31:0]                   cpu_rdata,
    output cache_pkg::mem_req_t           mem_req,
    output logic                          bus_query,
    output cache_pkg::bus_cmd_t           bus_cmd,
    output logic                          idle,
    output logic                          tag_we [`CACHE_WAYS],
    output cache_pkg::tag_entry_t         tag_wr,
    output logic                          data_we [`CACHE_WAYS],
    output logic [`CACHE_LINE_BITS/8-1:0] data_bmask,
    output cache_pkg::line_t              data_wr,
    output logic                          plru_touch,
    output cache_pkg::way_t               plru_way
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate,
        st_stall,
        st_acquire_bus,
        st_bus_command
    } state_t;

    state_t state, next_state;
    logic   upgrade_done;    // Invalidate already sent for this write
    logic   fill_shared;

    logic [`CACHE_TAG_BITS-1:0]   req_tag;
    logic [`CACHE_INDEX_BITS-1:0] req_index;
    logic [2:0]                   req_word;
    logic [`CACHE_ADDR_BITS-1:0]  line_addr;
    logic                         is_write;
    logic                         hit;
    way_t                         hit_way;
    tag_entry_t                   hit_tag;
    tag_entry_t                   victim_tag;
    logic [31:0]                  rmask_bits;

    assign req_tag    = cpu_req.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign req_index  = cpu_req.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    assign req_word   = cpu_req.addr[4:2];
    assign line_addr  = {cpu_req.addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS],
                         {`CACHE_OFFSET_BITS{1'b0}}};
    assign is_write   = |cpu_req.wmask;
    assign idle       = (state == st_idle);

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!hit && tag_hit(tag_rd[w], req_tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_tag    = tag_rd[hit_way];
    assign victim_tag = tag_rd[victim];
    assign rmask_bits = {{8{cpu_req.rmask[3]}}, {8{cpu_req.rmask[2]}},
                         {8{cpu_req.rmask[1]}}, {8{cpu_req.rmask[0]}}};
    assign cpu_rdata  = data_rd[hit_way][32*req_word +: 32] & rmask_bits;

    always_comb begin
        next_state = state;
        cpu_resp   = 1'b0;
        mem_req    = '0;
        bus_query  = 1'b0;
        bus_cmd    = '{cmd: BUS_NONE, addr: '0};
        tag_we     = '{default: 1'b0};
        data_we    = '{default: 1'b0};
        tag_wr     = '{state: MESI_M, dirty: 1'b1, tag: req_tag};
        data_bmask = '1;
        data_wr    = {8{cpu_req.wdata}};    // Word copied to every slot
        plru_touch = 1'b0;
        plru_way   = hit_way;
        case (state)
            st_idle: if (cpu_req.valid) next_state = st_compare;
            st_compare: begin
                if (!hit) begin
                    if (victim_tag.state != MESI_I && victim_tag.dirty) begin
                        next_state = st_write_back;
                    end else begin
                        next_state = st_acquire_bus;
                    end
                end else if (is_write && hit_tag.state == MESI_S && !upgrade_done) begin
                    next_state = st_acquire_bus;    // Other copies go first
                end else begin
                    cpu_resp   = 1'b1;
                    plru_touch = 1'b1;
                    next_state = st_idle;
                    if (is_write) begin
                        tag_we[hit_way]  = 1'b1;
                        data_we[hit_way] = 1'b1;
                        data_bmask = {{(`CACHE_LINE_BITS/8-4){1'b0}}, cpu_req.wmask}
                                     << (4 * req_word);
                    end
                end
            end
            st_write_back: begin
                mem_req.write = 1'b1;
                mem_req.addr  = {victim_tag.tag, req_index, {`CACHE_OFFSET_BITS{1'b0}}};
                mem_req.wdata = data_rd[victim];
                if (mem_rsp.valid) next_state = st_acquire_bus;
            end
            st_acquire_bus: begin
                bus_query = 1'b1;
                if (bus_ready) next_state = st_bus_command;
            end
            st_bus_command: begin
                bus_cmd.cmd  = hit ? BUS_INV : BUS_RD;    // Hit here means upgrade
                bus_cmd.addr = line_addr;
                if (bus_rsp.valid) next_state = hit ? st_stall : st_allocate;
            end
            st_allocate: begin
                mem_req.read = 1'b1;
                mem_req.addr = line_addr;
                if (mem_rsp.valid) begin
                    tag_we[victim]  = 1'b1;
                    data_we[victim] = 1'b1;
                    tag_wr  = '{state: fill_shared ? MESI_S : MESI_E, dirty: 1'b0, tag: req_tag};
                    data_wr = mem_rsp.rdata;
                    next_state = st_stall;
                end
            end
            st_stall: next_state = st_compare;    // Array read catches up
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            upgrade_done <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_bus_command && bus_rsp.valid && hit) begin
                upgrade_done <= 1'b1;
            end else if (cpu_resp) begin
                upgrade_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_bus_command && bus_rsp.valid) fill_shared <= bus_rsp.shared;
    end

    // Memory answers only while exactly one request is pending
    assert property (@(posedge clk) disable iff (rst)
        mem_rsp.valid |-> mem_req.read ^ mem_req.write)
        else $error("cache_controller: memory response with no request pending");

endmodule

//--- hdl/snoop_responder.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module snoop_responder (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::snoop_req_t        snoop_req,
    input  cache_pkg::tag_entry_t        tag_rd [`CACHE_WAYS],
    input  cache_pkg::line_t             data_rd [`CACHE_WAYS],
    input  logic                         ctrl_idle,
    output logic [`CACHE_INDEX_BITS-1:0] port_index,
    output cache_pkg::snoop_rsp_t        snoop_rsp,
    output logic                         tag_we [`CACHE_WAYS],
    output cache_pkg::tag_entry_t        tag_wr
);
    import cache_pkg::*;

    snoop_req_t req_q;
    logic       hit;
    way_t       hit_way;
    tag_entry_t hit_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= snoop_req.valid;
        end
        req_q.cmd  <= snoop_req.cmd;
        req_q.addr <= snoop_req.addr;
    end

    // Read with the new snoop, write back with the registered one
    assign port_index = req_q.valid ? req_q.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS]
                                    : snoop_req.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (req_q.valid && !hit
                && tag_hit(tag_rd[w], req_q.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS])) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_tag = tag_rd[hit_way];

    always_comb begin
        snoop_rsp = '{valid: req_q.valid, hit: hit, dirty: 1'b0, data: '0};
        tag_we    = '{default: 1'b0};
        tag_wr    = '{state: MESI_I, dirty: 1'b0, tag: hit_tag.tag};
        if (hit && req_q.cmd != BUS_NONE) begin
            tag_we[hit_way] = 1'b1;
            if (req_q.cmd == BUS_RD) begin
                snoop_rsp.dirty = hit_tag.dirty;
                snoop_rsp.data  = data_rd[hit_way];
                if (!hit_tag.dirty) tag_wr.state = MESI_S;    // Clean copy stays shared
            end
        end
    end

    // Snoops land between CPU requests and never back to back
    assert property (@(posedge clk) disable iff (rst)
        snoop_req.valid |-> ctrl_idle && !req_q.valid)
        else $error("snoop_responder: snoop while controller busy");

endmodule

//--- hdl/snoop_d_cache.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module snoop_d_cache (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::cpu_req_t    cpu_req,
    output logic                   cpu_resp,
    output logic [31:0]            cpu_rdata,
    output cache_pkg::mem_req_t    mem_req,
    input  cache_pkg::mem_rsp_t    mem_rsp,
    output logic                   bus_query,
    input  logic                   bus_ready,
    output cache_pkg::bus_cmd_t    bus_cmd,
    input  cache_pkg::bus_rsp_t    bus_rsp,
    input  cache_pkg::snoop_req_t  snoop_req,
    output cache_pkg::snoop_rsp_t  snoop_rsp
);
    import cache_pkg::*;

    logic [`CACHE_INDEX_BITS-1:0]  cpu_index;
    logic [`CACHE_INDEX_BITS-1:0]  snoop_index;
    tag_entry_t                    tag_a [`CACHE_WAYS];
    tag_entry_t                    tag_b [`CACHE_WAYS];
    line_t                         data_a [`CACHE_WAYS];
    line_t                         data_b [`CACHE_WAYS];
    logic                          ctrl_tag_we [`CACHE_WAYS];
    logic                          snoop_tag_we [`CACHE_WAYS];
    logic                          data_we [`CACHE_WAYS];
    tag_entry_t                    ctrl_tag_wr;
    tag_entry_t                    snoop_tag_wr;
    logic [`CACHE_LINE_BITS/8-1:0] data_bmask;
    line_t                         data_wr;
    logic                          ctrl_idle;
    logic                          plru_touch;
    way_t                          plru_way;
    way_t                          victim;

    assign cpu_index = cpu_req.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_bank #(.entry_t(tag_entry_t), .DEPTH(`CACHE_SETS)) u_tag (
            .clk     (clk),
            .rst     (rst),
            .a_addr  (cpu_index),
            .a_we    (ctrl_tag_we[w]),
            .a_bmask ('1),
            .a_din   (ctrl_tag_wr),
            .a_dout  (tag_a[w]),
            .b_addr  (snoop_index),
            .b_we    (snoop_tag_we[w]),
            .b_din   (snoop_tag_wr),
            .b_dout  (tag_b[w])
        );

        // Snoop port only reads the data
        cache_bank #(.entry_t(line_t), .DEPTH(`CACHE_SETS)) u_data (
            .clk     (clk),
            .rst     (rst),
            .a_addr  (cpu_index),
            .a_we    (data_we[w]),
            .a_bmask (data_bmask),
            .a_din   (data_wr),
            .a_dout  (data_a[w]),
            .b_addr  (snoop_index),
            .b_we    (1'b0),
            .b_din   ('0),
            .b_dout  (data_b[w])
        );
    end

    plru_tree u_plru (
        .clk       (clk),
        .rst       (rst),
        .index     (cpu_index),
        .touch     (plru_touch),
        .touch_way (plru_way),
        .victim    (victim)
    );

    cache_controller u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .mem_rsp    (mem_rsp),
        .bus_ready  (bus_ready),
        .bus_rsp    (bus_rsp),
        .tag_rd     (tag_a),
        .data_rd    (data_a),
        .victim     (victim),
        .cpu_resp   (cpu_resp),
        .cpu_rdata  (cpu_rdata),
        .mem_req    (mem_req),
        .bus_query  (bus_query),
        .bus_cmd    (bus_cmd),
        .idle       (ctrl_idle),
        .tag_we     (ctrl_tag_we),
        .tag_wr     (ctrl_tag_wr),
        .data_we    (data_we),
        .data_bmask (data_bmask),
        .data_wr    (data_wr),
        .plru_touch (plru_touch),
        .plru_way   (plru_way)
    );

    snoop_responder u_snoop (
        .clk        (clk),
        .rst        (rst),
        .snoop_req  (snoop_req),
        .tag_rd     (tag_b),
        .data_rd    (data_b),
        .ctrl_idle  (ctrl_idle),
        .port_index (snoop_index),
        .snoop_rsp  (snoop_rsp),
        .tag_we     (snoop_tag_we),
        .tag_wr     (snoop_tag_wr)
    );

endmodule

//--- test/snoop_d_cache_tb.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module snoop_d_cache_tb;
    import cache_pkg::*;

    localparam int MAX_CYCLES = 3000;    // About 20 accesses of up to 25 cycles, times 6

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    logic        cpu_resp;
    logic [31:0] cpu_rdata;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic        bus_query;
    logic        bus_ready;
    bus_cmd_t    bus_cmd;
    bus_rsp_t    bus_rsp;
    snoop_req_t  snoop_req;
    snoop_rsp_t  snoop_rsp;

    int errors;
    int cycles;
    int mem_reads;
    int mem_writes;
    int queries;
    int inv_count;
    logic [31:0] last_bus_addr;
    logic        bus_shared;    // Shared answer for the next bus read

    line_t       mem_lines [logic [31:0]];
    logic [7:0]  shadow [logic [31:0]];    // Current value of every written byte
    logic [31:0] wb_expect [$];

    // Reference cache directory
    logic [22:0] m_tag [16][4];
    logic        m_valid [16][4];
    logic        m_dirty [16][4];
    logic [2:0]  m_tree [16];    // [2] upper half older, [1] way1 older, [0] way3 older

    snoop_d_cache UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .bus_query (bus_query),
        .bus_ready (bus_ready),
        .bus_cmd   (bus_cmd),
        .bus_rsp   (bus_rsp),
        .snoop_req (snoop_req),
        .snoop_rsp (snoop_rsp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] mk_addr(logic [22:0] tag, int set, int word);
        return {tag, set[3:0], word[2:0], 2'b00};
    endfunction

    function automatic logic [7:0] pattern_byte(logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] shadow_byte(logic [31:0] a);
        if (shadow.exists(a)) return shadow[a];
        return pattern_byte(a);
    endfunction

    function automatic line_t shadow_line(logic [31:0] base);
        line_t l;
        for (int b = 0; b < 32; b++) l[8*b +: 8] = shadow_byte(base + b);
        return l;
    endfunction

    function automatic line_t memory_line(logic [31:0] base);
        line_t l;
        if (mem_lines.exists(base)) return mem_lines[base];
        for (int b = 0; b < 32; b++) l[8*b +: 8] = pattern_byte(base + b);
        return l;
    endfunction

    function automatic int lru_way(logic [2:0] t);
        return t[2] ? (t[0] ? 3 : 2) : (t[1] ? 1 : 0);
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Directory update for one CPU access, queues the expected write-back
    task automatic model_access(input logic [31:0] addr, input logic is_write);
        int          set;
        int          way;
        logic        hit;
        logic [22:0] tag;
        set = addr[8:5];
        tag = addr[31:9];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 4; w++) begin
            if (!hit && m_valid[set][w] && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = lru_way(m_tree[set]);
            if (m_valid[set][way] && m_dirty[set][way]) begin
                wb_expect.push_back({m_tag[set][way], set[3:0], 5'b0});
            end
            m_valid[set][way] = 1'b1;
            m_tag[set][way]   = tag;
            m_dirty[set][way] = 1'b0;
        end
        if (is_write) m_dirty[set][way] = 1'b1;
        if (way < 2) begin
            m_tree[set][2] = 1'b1;
            m_tree[set][1] = (way == 0);
        end else begin
            m_tree[set][2] = 1'b0;
            m_tree[set][0] = (way == 2);
        end
    endtask

    task automatic cpu_access(input logic [31:0] addr, input logic [3:0] rmask,
                              input logic [3:0] wmask, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int lat);
        @(posedge clk);
        #1 cpu_req = '{addr: addr, rmask: rmask, wmask: wmask, wdata: wdata, valid: 1'b1};
        lat = 0;
        forever begin
            @(negedge clk);
            if (cpu_resp) break;
            lat++;
        end
        rdata = cpu_rdata;
        @(posedge clk);
        #1 cpu_req.valid = 1'b0;
    endtask

    task automatic cpu_read(input logic [31:0] addr, input logic [3:0] rmask, output int lat);
        logic [31:0] got;
        logic [31:0] exp;
        model_access(addr, 1'b0);
        for (int i = 0; i < 4; i++) begin
            exp[8*i +: 8] = rmask[i] ? shadow_byte({addr[31:2], 2'b00} + i) : 8'h00;
        end
        cpu_access(addr, rmask, 4'h0, 32'h0, got, lat);
        check_value("cpu_rdata", got, exp);
    endtask

    task automatic cpu_write(input logic [31:0] addr, input logic [3:0] wmask,
                             input logic [31:0] wdata);
        logic [31:0] unused;
        int          lat;
        model_access(addr, 1'b1);
        cpu_access(addr, 4'h0, wmask, wdata, unused, lat);
        for (int i = 0; i < 4; i++) begin
            if (wmask[i]) shadow[{addr[31:2], 2'b00} + i] = wdata[8*i +: 8];
        end
    endtask

    task automatic snoop_check(input bus_cmd_e cmd, input logic [31:0] addr);
        logic [31:0] base;
        logic        exp_hit;
        logic        exp_dirty;
        int          set;
        int          way;
        base      = {addr[31:5], 5'b0};
        set       = addr[8:5];
        exp_hit   = 1'b0;
        exp_dirty = 1'b0;
        way       = 0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == addr[31:9]) begin
                exp_hit   = 1'b1;
                exp_dirty = m_dirty[set][w];
                way       = w;
            end
        end
        @(posedge clk);
        #1 snoop_req = '{valid: 1'b1, cmd: cmd, addr: addr};
        @(posedge clk);
        #1 snoop_req.valid = 1'b0;
        @(negedge clk);
        assert (snoop_rsp.valid) else begin
            errors++;
            $display("snoop reply missing one cycle after the request at %0t", $time);
        end
        check_value("snoop_rsp.hit", snoop_rsp.hit, exp_hit);
        check_value("snoop_rsp.dirty", snoop_rsp.dirty, (cmd == BUS_RD) && exp_dirty);
        if (cmd == BUS_RD && exp_hit) begin
            check_value("snoop_rsp.data", snoop_rsp.data, shadow_line(base));
        end
        if (exp_hit && (cmd == BUS_INV || exp_dirty)) m_valid[set][way] = 1'b0;
        if (cmd == BUS_RD && exp_hit && exp_dirty) begin
            mem_lines[base] = shadow_line(base);    // Requester updates memory
        end
    endtask

    // Memory answers after 1 to 4 cycles
    always begin : memory_model
        line_t line;
        int    delay;
        @(negedge clk);
        if (!rst && (mem_req.read || mem_req.write)) begin
            delay = $urandom_range(4, 1);
            line  = '0;
            if (mem_req.write) begin
                mem_writes++;
                if (wb_expect.size() == 0) begin
                    errors++;
                    $display("unexpected memory write to %h at %0t", mem_req.addr, $time);
                end else begin
                    check_value("mem_req.addr", mem_req.addr, wb_expect.pop_front());
                end
                check_value("mem_req.wdata", mem_req.wdata, shadow_line(mem_req.addr));
                mem_lines[mem_req.addr] = mem_req.wdata;
            end else begin
                mem_reads++;
                check_value("mem_req.addr", mem_req.addr, {cpu_req.addr[31:5], 5'b0});
                line = memory_line(mem_req.addr);
            end
            repeat (delay) @(posedge clk);
            #1 mem_rsp = '{valid: 1'b1, rdata: line};
            @(posedge clk);
            #1 mem_rsp.valid = 1'b0;
        end
    end

    always begin : bus_model
        int delay;
        @(negedge clk);
        if (!rst && bus_query) begin
            queries++;
            delay = $urandom_range(3, 1);
            repeat (delay) @(posedge clk);
            #1 bus_ready = 1'b1;
            @(posedge clk);
            #1 bus_ready = 1'b0;
            @(negedge clk);
            assert (bus_cmd.cmd != BUS_NONE) else begin
                errors++;
                $display("no bus command after the grant at %0t", $time);
            end
            check_value("bus_cmd.addr", bus_cmd.addr, {cpu_req.addr[31:5], 5'b0});
            last_bus_addr = bus_cmd.addr;
            if (bus_cmd.cmd == BUS_INV) inv_count++;
            repeat (delay) @(posedge clk);
            #1 bus_rsp = '{valid: 1'b1, shared: bus_shared};
            @(posedge clk);
            #1 bus_rsp.valid = 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) |-> mem_req.addr[4:0] == 5'd0)
        else begin
            errors++;
            $display("memory request address not line aligned at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        bus_cmd.cmd != BUS_NONE |-> bus_cmd.addr[4:0] == 5'd0)
        else begin
            errors++;
            $display("bus command address not line aligned at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) cpu_resp |-> cpu_req.valid)
        else begin
            errors++;
            $display("cpu_resp without a request at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) snoop_req.valid |=> snoop_rsp.valid)
        else begin
            errors++;
            $display("snoop reply not one cycle after the request at %0t", $time);
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, errors: %0d", cycles, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        int          lat;
        int          r0;
        int          c0;
        logic [31:0] a;
        clk        = 1'b0;
        rst        = 1'b1;
        cpu_req    = '0;
        mem_rsp    = '0;
        bus_ready  = 1'b0;
        bus_rsp    = '0;
        snoop_req  = '0;
        bus_shared = 1'b0;
        for (int s = 0; s < 16; s++) begin
            m_tree[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        void'($urandom(32'h7161_7d59));
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // Read miss, then a hit in one cycle
        a  = mk_addr(23'h100, 1, 3);
        r0 = mem_reads;
        cpu_read(a, 4'hf, lat);
        check_value("memory reads", mem_reads, r0 + 1);
        cpu_read(a, 4'b0110, lat);
        check_value("hit latency", lat, 1);
        check_value("memory reads", mem_reads, r0 + 1);

        // Exclusive line takes a write silently
        a = mk_addr(23'h200, 2, 5);
        cpu_read(a, 4'hf, lat);
        c0 = queries;
        cpu_write(a, 4'b1010, 32'hdead_beef);
        check_value("bus queries", queries, c0);
        cpu_read(a, 4'hf, lat);

        // Shared line needs an invalidate first
        bus_shared = 1'b1;
        a = mk_addr(23'h300, 3, 0);
        cpu_read(a, 4'hf, lat);
        c0 = inv_count;
        cpu_write(a, 4'b0011, 32'h1234_abcd);
        check_value("invalidate count", inv_count, c0 + 1);
        check_value("bus_cmd.addr", last_bus_addr, {a[31:5], 5'b0});
        cpu_read(a, 4'hf, lat);
        bus_shared = 1'b0;

        // Fifth line in a full set evicts the tree victim
        for (int k = 0; k < 4; k++) cpu_write(mk_addr(23'h400 + k, 4, k), 4'hf, $urandom);
        c0 = mem_writes;
        cpu_read(mk_addr(23'h404, 4, 1), 4'hf, lat);
        check_value("memory writes", mem_writes, c0 + 1);
        check_value("pending write-backs", wb_expect.size(), 0);

        // Snooped read of a dirty line
        a = mk_addr(23'h500, 5, 2);
        cpu_write(a, 4'hf, 32'hcafe_f00d);
        snoop_check(BUS_RD, a);
        r0 = mem_reads;
        cpu_read(a, 4'hf, lat);
        check_value("memory reads", mem_reads, r0 + 1);

        // Snooped invalidate, then a snoop that misses
        a = mk_addr(23'h600, 6, 4);
        cpu_read(a, 4'hf, lat);
        snoop_check(BUS_INV, a);
        r0 = mem_reads;
        cpu_read(a, 4'hf, lat);
        check_value("memory reads", mem_reads, r0 + 1);
        snoop_check(BUS_RD, mk_addr(23'h700, 7, 0));

        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- snoop_d_cache.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_bank.sv
hdl/plru_tree.sv
hdl/cache_controller.sv
hdl/snoop_responder.sv
hdl/snoop_d_cache.sv
test/snoop_d_cache_tb.sv

//--- Makefile
.PHONY: all lint clean

all: obj_dir/Vsnoop_d_cache_tb
	./obj_dir/Vsnoop_d_cache_tb | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

obj_dir/Vsnoop_d_cache_tb: snoop_d_cache.f hdl/*.sv hdl/*.svh test/*.sv
	verilator --binary --timing --assert -Wno-fatal \
		--top-module snoop_d_cache_tb -f snoop_d_cache.f

lint:
	verilator --lint-only --timing -Wall --top-module snoop_d_cache_tb -f snoop_d_cache.f

clean:
	rm -rf obj_dir sim.log
